/* all.f */
+incdir+.
recovery_pkg.sv
rx_fifo.sv
width_converter_8to32.sv
recovery_pec.sv
recovery_receiver.sv
tti_rx_router.sv
recovery_handler.sv
tb_recovery_handler.sv

/* Makefile */
SRCS := $(wildcard *.sv *.svh)

obj_dir/Vtb_recovery_handler: all.f $(SRCS)
	verilator --binary --timing -Wno-fatal --top-module tb_recovery_handler -f all.f -o Vtb_recovery_handler

run: obj_dir/Vtb_recovery_handler
	@out="$$(./obj_dir/Vtb_recovery_handler)"; echo "$$out"; \
	echo "$$out" | grep -q "TEST RESULT: PASS"

clean:
	rm -rf obj_dir

.PHONY: run clean

/* tb_recovery_model.svh */
// Reference models for the recovery RX testbench, included inside the testbench top module
`ifndef TB_RECOVERY_MODEL_SVH
`define TB_RECOVERY_MODEL_SVH

// CRC-8, x^8 + x^2 + x + 1, MSB first, starting from zero
function automatic pec_t crc8(input byte_t b[$]);
  pec_t crc;
  logic fb;
  crc = 8'h00;
  foreach (b[i]) begin
    for (int k = 7; k >= 0; k--) begin
      fb  = crc[7] ^ b[i][k];
      crc = {crc[6:0], 1'b0};
      if (fb) begin
        crc = crc ^ 8'h07;
      end
    end
  end
  return crc;
endfunction

// Little-endian word from four bytes starting at first, zero past the end
function automatic word_t pack_word(input byte_t b[$], input int first);
  word_t w;
  w = '0;
  for (int i = 0; i < 4; i++) begin
    if (first + i < b.size()) begin
      w[i*8 +: 8] = b[first + i];
    end
  end
  return w;
endfunction

function automatic rec_cmd_t expected_cmd(input byte_t cmd, input len_t len, input int count,
                                          input bit pec_ok);
  rec_cmd_t c;
  c.valid = 1'b1;
  c.cmd   = cmd;
  c.len   = len;
  // Bad PEC or a descriptor count other than header plus payload plus PEC
  c.error = !pec_ok || (count != int'(len) + 4);
  return c;
endfunction

`endif

/* tb_recovery_handler.sv */
// Testbench top for the recovery RX path that the Makefile builds from all.f
`timescale 1ns/10ps
`default_nettype none

module tb_recovery_handler
  import recovery_pkg::*;
();

  `include "tb_recovery_model.svh"

  localparam int MaxCycles = 4000;
  localparam int WaitLimit = 64;
  localparam int DescDepth = 16;
  localparam int DataDepth = 16;

  logic     clk_i;
  logic     rst_i;
  logic     recovery_mode_i;
  logic     ctl_rx_desc_wvalid_i;
  logic     ctl_rx_desc_wready_o;
  desc_t    ctl_rx_desc_wdata_i;
  logic     ctl_rx_desc_full_o;
  logic     ctl_rx_desc_empty_o;
  logic     ctl_rx_data_wvalid_i;
  logic     ctl_rx_data_wready_o;
  byte_t    ctl_rx_data_wdata_i;
  logic     ctl_rx_data_wflush_i;
  logic     ctl_rx_data_full_o;
  logic     ctl_rx_data_empty_o;
  logic     csr_rx_desc_req_i;
  logic     csr_rx_desc_ack_o;
  word_t    csr_rx_desc_data_o;
  logic     csr_rx_data_req_i;
  logic     csr_rx_data_ack_o;
  word_t    csr_rx_data_data_o;
  rec_cmd_t cmd_o;

  int       seed;
  int       errors;
  int       checks;
  int       tests;
  int       errors_at_start;
  int       cycle_cnt;
  int       accept_edge;
  string    test_name;
  rec_cmd_t exp_cmd[$];
  word_t    exp_desc[$];
  word_t    exp_data[$];

  recovery_handler #(
    .DescDepth (DescDepth),
    .DataDepth (DataDepth)
  ) dut (
    .clk_i,
    .rst_i,
    .recovery_mode_i,
    .ctl_rx_desc_wvalid_i,
    .ctl_rx_desc_wready_o,
    .ctl_rx_desc_wdata_i,
    .ctl_rx_desc_full_o,
    .ctl_rx_desc_empty_o,
    .ctl_rx_data_wvalid_i,
    .ctl_rx_data_wready_o,
    .ctl_rx_data_wdata_i,
    .ctl_rx_data_wflush_i,
    .ctl_rx_data_full_o,
    .ctl_rx_data_empty_o,
    .csr_rx_desc_req_i,
    .csr_rx_desc_ack_o,
    .csr_rx_desc_data_o,
    .csr_rx_data_req_i,
    .csr_rx_data_ack_o,
    .csr_rx_data_data_o,
    .cmd_o
  );

  always #5 clk_i = ~clk_i;

  task automatic compare_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
    checks++;
    if (expected !== actual) begin
      errors++;
      $display("Error: %s %s expected %h actual %h", test_name, what, expected, actual);
    end
  endtask

  task automatic report_failure(input string msg);
    errors++;
    $display("%s: %s", test_name, msg);
  endtask

  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= MaxCycles) begin
      $display("Timeout: run stopped after %0d cycles in %s", cycle_cnt, test_name);
      $display("TEST RESULT: FAIL");
      $finish;
    end
  end

  // Every command pulse and CSR ack is matched against the expected queues
  always @(posedge clk_i) begin
    if (!rst_i) begin
      if (cmd_o.valid) begin
        if (exp_cmd.size() == 0) begin
          report_failure("command reported when none was expected");
        end else begin
          compare_value("command", 32'(exp_cmd.pop_front()), 32'(cmd_o));
          compare_value("command latency", 32'd1, 32'(cycle_cnt - accept_edge));
        end
      end
      if (csr_rx_desc_ack_o) begin
        if (exp_desc.size() == 0) begin
          report_failure("descriptor ack when none was expected");
        end else begin
          compare_value("descriptor", exp_desc.pop_front(), csr_rx_desc_data_o);
        end
      end
      if (csr_rx_data_ack_o) begin
        if (exp_data.size() == 0) begin
          report_failure("data ack when none was expected");
        end else begin
          compare_value("data word", exp_data.pop_front(), csr_rx_data_data_o);
        end
      end
    end
  end

  task automatic start_test(input string name);
    test_name       = name;
    errors_at_start = errors;
  endtask

  task automatic end_test();
    tests++;
    $display("%s finished, %0d errors", test_name, errors - errors_at_start);
  endtask

  task automatic idle(input int n);
    repeat (n) @(posedge clk_i);
    #1;
  endtask

  task automatic send_desc(input desc_t d);
    int waited;
    waited               = 0;
    ctl_rx_desc_wdata_i  = d;
    ctl_rx_desc_wvalid_i = 1'b1;
    @(posedge clk_i);
    while (!ctl_rx_desc_wready_o && waited < WaitLimit) begin
      waited++;
      @(posedge clk_i);
    end
    if (!ctl_rx_desc_wready_o) begin
      report_failure("descriptor write was never accepted");
    end
    #1;
    ctl_rx_desc_wvalid_i = 1'b0;
  endtask

  task automatic send_byte(input byte_t b, input bit flush);
    int waited;
    waited               = 0;
    ctl_rx_data_wdata_i  = b;
    ctl_rx_data_wflush_i = flush;
    ctl_rx_data_wvalid_i = 1'b1;
    @(posedge clk_i);
    while (!ctl_rx_data_wready_o && waited < WaitLimit) begin
      waited++;
      @(posedge clk_i);
    end
    if (!ctl_rx_data_wready_o) begin
      report_failure("data byte was never accepted");
    end
    accept_edge = cycle_cnt;
    #1;
    ctl_rx_data_wvalid_i = 1'b0;
    ctl_rx_data_wflush_i = 1'b0;
  endtask

  // One req pulse and a check that the ack follows one cycle later
  task automatic read_csr(input bit from_desc);
    int   waited;
    logic ack;
    waited = 0;
    if (from_desc) begin
      csr_rx_desc_req_i = 1'b1;
    end else begin
      csr_rx_data_req_i = 1'b1;
    end
    @(posedge clk_i);
    #1;
    csr_rx_desc_req_i = 1'b0;
    csr_rx_data_req_i = 1'b0;
    do begin
      @(posedge clk_i);
      ack = from_desc ? csr_rx_desc_ack_o : csr_rx_data_ack_o;
      waited++;
    end while (!ack && waited < WaitLimit);
    if (!ack) begin
      report_failure("CSR read got no ack");
    end else begin
      compare_value("ack latency", 32'd1, 32'(waited));
    end
    #1;
  endtask

  task automatic run_packet(input int len, input int count, input bit corrupt);
    byte_t pkt[$];
    byte_t payload[$];
    byte_t cmd;
    pec_t  pec;
    int    rnd;
    int    waited;
    bit    seen;
    rnd = $random(seed);
    cmd = rnd[7:0];
    pkt.push_back(cmd);
    pkt.push_back(len[7:0]);
    pkt.push_back(len[15:8]);
    for (int i = 0; i < len; i++) begin
      rnd = $random(seed);
      payload.push_back(rnd[7:0]);
      pkt.push_back(rnd[7:0]);
    end
    pec = crc8(pkt);
    if (corrupt) begin
      pec = pec ^ 8'h5a;
    end
    exp_cmd.push_back(expected_cmd(cmd, len_t'(len), count, !corrupt));
    for (int i = 0; i < len; i += 4) begin
      exp_data.push_back(pack_word(payload, i));
    end
    send_desc(desc_t'(count));
    foreach (pkt[i]) begin
      send_byte(pkt[i], 1'b0);
    end
    send_byte(pec, 1'b0);
    waited = 0;
    seen   = 1'b0;
    while (!seen && waited < WaitLimit) begin
      @(posedge clk_i);
      seen = cmd_o.valid;
      waited++;
    end
    #1;
    if (!seen) begin
      report_failure("no command report after the PEC byte");
    end
    idle(2);
    // Held low even when the payload fills the data queue
    compare_value("data full", 32'd0, 32'(ctl_rx_data_full_o));
    for (int i = 0; i < (len + 3) / 4; i++) begin
      read_csr(1'b0);
    end
  endtask

  task automatic check_desc_blocked();
    bit seen;
    seen              = 1'b0;
    csr_rx_desc_req_i = 1'b1;
    @(posedge clk_i);
    #1;
    csr_rx_desc_req_i = 1'b0;
    repeat (3) begin
      @(posedge clk_i);
      if (csr_rx_desc_ack_o) begin
        seen = 1'b1;
      end
    end
    #1;
    if (seen) begin
      report_failure("descriptor read was acked in recovery mode");
    end
  endtask

  initial begin
    byte_t bytes[$];
    int    rnd;
    int    len;
    seed                 = 50;
    errors               = 0;
    checks               = 0;
    tests                = 0;
    cycle_cnt            = 0;
    accept_edge          = 0;
    test_name            = "reset";
    clk_i                = 1'b0;
    rst_i                = 1'b1;
    recovery_mode_i      = 1'b0;
    ctl_rx_desc_wvalid_i = 1'b0;
    ctl_rx_desc_wdata_i  = '0;
    ctl_rx_data_wvalid_i = 1'b0;
    ctl_rx_data_wdata_i  = '0;
    ctl_rx_data_wflush_i = 1'b0;
    csr_rx_desc_req_i    = 1'b0;
    csr_rx_data_req_i    = 1'b0;
    repeat (8) @(posedge clk_i);
    #1;
    rst_i = 1'b0;

    start_test("reset state");
    idle(1);
    compare_value("desc empty", 32'd1, 32'(ctl_rx_desc_empty_o));
    compare_value("data empty", 32'd1, 32'(ctl_rx_data_empty_o));
    compare_value("cmd valid", 32'd0, 32'(cmd_o.valid));
    end_test();

    start_test("normal descriptors");
    for (int i = 0; i < DescDepth; i++) begin
      rnd = $random(seed);
      exp_desc.push_back(word_t'(rnd));
      send_desc(desc_t'(rnd));
    end
    idle(1);
    compare_value("desc full", 32'd1, 32'(ctl_rx_desc_full_o));
    compare_value("desc empty", 32'd0, 32'(ctl_rx_desc_empty_o));
    // Full queue is hidden from the controller in recovery
    recovery_mode_i = 1'b1;
    idle(1);
    compare_value("desc full in recovery", 32'd0, 32'(ctl_rx_desc_full_o));
    recovery_mode_i = 1'b0;
    idle(1);
    for (int i = 0; i < DescDepth; i++) begin
      read_csr(1'b1);
    end
    // Empty queue acks with zero data
    exp_desc.push_back('0);
    read_csr(1'b1);
    end_test();

    start_test("normal data");
    bytes.delete();
    for (int i = 0; i < 12; i++) begin
      rnd = $random(seed);
      bytes.push_back(rnd[7:0]);
    end
    for (int i = 0; i < 12; i += 4) begin
      exp_data.push_back(pack_word(bytes, i));
    end
    foreach (bytes[i]) begin
      send_byte(bytes[i], 1'b0);
    end
    idle(2);
    repeat (3) read_csr(1'b0);
    bytes.delete();
    for (int i = 0; i < 6; i++) begin
      rnd = $random(seed);
      bytes.push_back(rnd[7:0]);
    end
    exp_data.push_back(pack_word(bytes, 0));
    exp_data.push_back(pack_word(bytes, 4));
    foreach (bytes[i]) begin
      send_byte(bytes[i], i == 5);
    end
    idle(2);
    repeat (2) read_csr(1'b0);
    end_test();

    recovery_mode_i = 1'b1;
    idle(2);

    start_test("recovery good");
    for (int p = 0; p < 4; p++) begin
      rnd = $random(seed);
      len = 1 + (rnd[7:0] % 12);
      run_packet(len, len + 4, 1'b0);
    end
    // Payload that fills the data queue
    run_packet(DataDepth * 4, DataDepth * 4 + 4, 1'b0);
    end_test();

    start_test("recovery bad pec");
    rnd = $random(seed);
    len = 1 + (rnd[7:0] % 12);
    run_packet(len, len + 4, 1'b1);
    end_test();

    start_test("recovery bad count");
    rnd = $random(seed);
    len = 1 + (rnd[7:0] % 12);
    run_packet(len, len + 5, 1'b0);
    end_test();

    start_test("recovery blocking");
    compare_value("desc empty", 32'd0, 32'(ctl_rx_desc_empty_o));
    compare_value("data empty", 32'd0, 32'(ctl_rx_data_empty_o));
    check_desc_blocked();
    end_test();

    idle(4);
    if (exp_cmd.size() != 0 || exp_desc.size() != 0 || exp_data.size() != 0) begin
      report_failure("some expected responses never arrived");
    end
    $display("Tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* recovery_handler.sv */
// Top of the TTI receive path with recovery receiver, instantiate as the target RX block
`timescale 1ns/10ps
`default_nettype none

module recovery_handler
  import recovery_pkg::*;
#(
  parameter int unsigned DescDepth = 16,
  parameter int unsigned DataDepth = 16
) (
  input  logic     clk_i,
  input  logic     rst_i,
  input  logic     recovery_mode_i,

  input  logic     ctl_rx_desc_wvalid_i,
  output logic     ctl_rx_desc_wready_o,
  input  desc_t    ctl_rx_desc_wdata_i,
  output logic     ctl_rx_desc_full_o,
  output logic     ctl_rx_desc_empty_o,

  input  logic     ctl_rx_data_wvalid_i,
  output logic     ctl_rx_data_wready_o,
  input  byte_t    ctl_rx_data_wdata_i,
  input  logic     ctl_rx_data_wflush_i,
  output logic     ctl_rx_data_full_o,
  output logic     ctl_rx_data_empty_o,

  input  logic     csr_rx_desc_req_i,
  output logic     csr_rx_desc_ack_o,
  output word_t    csr_rx_desc_data_o,

  input  logic     csr_rx_data_req_i,
  output logic     csr_rx_data_ack_o,
  output word_t    csr_rx_data_data_o,

  output rec_cmd_t cmd_o
);

  // Descriptor queue
  logic         dq_wvalid;
  logic         dq_wready;
  word_t        dq_wdata;
  logic         dq_full;
  logic         dq_empty;
  logic         dq_req;
  logic         dq_ack;
  word_t        dq_rdata;

  // Data queue and packer
  logic         data_full;
  logic         data_empty;
  logic         data_wvalid;
  logic         data_wready;
  word_t        data_wdata;
  byte_stream_t conv_sink;
  logic         conv_sink_ready;

  // Receiver
  logic         rec_desc_valid;
  logic         rec_desc_ready;
  desc_t        rec_desc_data;
  byte_stream_t rec_data;
  logic         rec_data_ready;
  logic         rec_select;
  logic         rec_flush;
  pec_t         pec_crc;
  logic         pec_enable;
  logic         pec_clear;

  tti_rx_router u_router (
    .recovery_mode_i,
    .ctl_desc_wvalid_i (ctl_rx_desc_wvalid_i),
    .ctl_desc_wready_o (ctl_rx_desc_wready_o),
    .ctl_desc_wdata_i  (ctl_rx_desc_wdata_i),
    .ctl_desc_full_o   (ctl_rx_desc_full_o),
    .ctl_desc_empty_o  (ctl_rx_desc_empty_o),
    .ctl_data_wvalid_i (ctl_rx_data_wvalid_i),
    .ctl_data_wready_o (ctl_rx_data_wready_o),
    .ctl_data_wdata_i  (ctl_rx_data_wdata_i),
    .ctl_data_wflush_i (ctl_rx_data_wflush_i),
    .ctl_data_full_o   (ctl_rx_data_full_o),
    .ctl_data_empty_o  (ctl_rx_data_empty_o),
    .rec_desc_valid_o  (rec_desc_valid),
    .rec_desc_ready_i  (rec_desc_ready),
    .rec_desc_data_o   (rec_desc_data),
    .rec_data_o        (rec_data),
    .rec_data_ready_i  (rec_data_ready),
    .rec_select_i      (rec_select),
    .rec_flush_i       (rec_flush),
    .conv_sink_o       (conv_sink),
    .conv_sink_ready_i (conv_sink_ready),
    .dq_wvalid_o       (dq_wvalid),
    .dq_wready_i       (dq_wready),
    .dq_wdata_o        (dq_wdata),
    .dq_full_i         (dq_full),
    .dq_empty_i        (dq_empty),
    .dq_req_o          (dq_req),
    .dq_ack_i          (dq_ack),
    .dq_rdata_i        (dq_rdata),
    .data_full_i       (data_full),
    .data_empty_i      (data_empty),
    .csr_desc_req_i    (csr_rx_desc_req_i),
    .csr_desc_ack_o    (csr_rx_desc_ack_o),
    .csr_desc_data_o   (csr_rx_desc_data_o)
  );

  rx_fifo #(
    .Depth (DescDepth)
  ) desc_queue (
    .clk_i,
    .rst_i,
    .wvalid_i (dq_wvalid),
    .wready_o (dq_wready),
    .wdata_i  (dq_wdata),
    .req_i    (dq_req),
    .ack_o    (dq_ack),
    .rdata_o  (dq_rdata),
    .full_o   (dq_full),
    .empty_o  (dq_empty)
  );

  width_converter_8to32 u_conv (
    .clk_i,
    .rst_i,
    .sink_i         (conv_sink),
    .sink_ready_o   (conv_sink_ready),
    .source_valid_o (data_wvalid),
    .source_ready_i (data_wready),
    .source_data_o  (data_wdata)
  );

  // Readable by software in either mode
  rx_fifo #(
    .Depth (DataDepth)
  ) data_queue (
    .clk_i,
    .rst_i,
    .wvalid_i (data_wvalid),
    .wready_o (data_wready),
    .wdata_i  (data_wdata),
    .req_i    (csr_rx_data_req_i),
    .ack_o    (csr_rx_data_ack_o),
    .rdata_o  (csr_rx_data_data_o),
    .full_o   (data_full),
    .empty_o  (data_empty)
  );

  recovery_pec u_pec (
    .clk_i,
    .rst_i,
    .clear_i (pec_clear),
    .valid_i (pec_enable),
    .dat_i   (ctl_rx_data_wdata_i),
    .crc_o   (pec_crc)
  );

  recovery_receiver u_receiver (
    .clk_i,
    .rst_i,
    .desc_valid_i        (rec_desc_valid),
    .desc_ready_o        (rec_desc_ready),
    .desc_data_i         (rec_desc_data),
    .data_i              (rec_data),
    .data_ready_o        (rec_data_ready),
    .data_queue_select_o (rec_select),
    .data_queue_flush_o  (rec_flush),
    .data_queue_ready_i  (conv_sink_ready),
    .pec_crc_i           (pec_crc),
    .pec_enable_o        (pec_enable),
    .pec_clear_o         (pec_clear),
    .cmd_o
  );

endmodule

`default_nettype wire

/* tti_rx_router.sv */
// Mode and select muxing between controller ports, RX queues, recovery receiver and CSR
`timescale 1ns/10ps
`default_nettype none

module tti_rx_router
  import recovery_pkg::*;
(
  input  logic         recovery_mode_i,
  // Controller descriptor port
  input  logic         ctl_desc_wvalid_i,
  output logic         ctl_desc_wready_o,
  input  desc_t        ctl_desc_wdata_i,
  output logic         ctl_desc_full_o,
  output logic         ctl_desc_empty_o,
  // Controller byte port
  input  logic         ctl_data_wvalid_i,
  output logic         ctl_data_wready_o,
  input  byte_t        ctl_data_wdata_i,
  input  logic         ctl_data_wflush_i,
  output logic         ctl_data_full_o,
  output logic         ctl_data_empty_o,
  // Recovery receiver
  output logic         rec_desc_valid_o,
  input  logic         rec_desc_ready_i,
  output desc_t        rec_desc_data_o,
  output byte_stream_t rec_data_o,
  input  logic         rec_data_ready_i,
  input  logic         rec_select_i,
  input  logic         rec_flush_i,
  // Converter sink
  output byte_stream_t conv_sink_o,
  input  logic         conv_sink_ready_i,
  // Descriptor FIFO
  output logic         dq_wvalid_o,
  input  logic         dq_wready_i,
  output word_t        dq_wdata_o,
  input  logic         dq_full_i,
  input  logic         dq_empty_i,
  output logic         dq_req_o,
  input  logic         dq_ack_i,
  input  word_t        dq_rdata_i,
  // Data FIFO flags
  input  logic         data_full_i,
  input  logic         data_empty_i,
  // CSR descriptor read
  input  logic         csr_desc_req_i,
  output logic         csr_desc_ack_o,
  output word_t        csr_desc_data_o
);

  assign dq_wdata_o      = ctl_desc_wdata_i;
  assign rec_desc_data_o = ctl_desc_wdata_i;

  always_comb begin
    if (recovery_mode_i) begin
      rec_desc_valid_o  = ctl_desc_wvalid_i;
      dq_wvalid_o       = 1'b0;
      ctl_desc_wready_o = rec_desc_ready_i;
      ctl_desc_full_o   = 1'b0;
      ctl_desc_empty_o  = 1'b0;
      // Descriptor queue is off limits to software in recovery
      dq_req_o          = 1'b0;
      csr_desc_ack_o    = 1'b0;
      csr_desc_data_o   = '0;
    end else begin
      rec_desc_valid_o  = 1'b0;
      dq_wvalid_o       = ctl_desc_wvalid_i;
      ctl_desc_wready_o = dq_wready_i;
      ctl_desc_full_o   = dq_full_i;
      ctl_desc_empty_o  = dq_empty_i;
      dq_req_o          = csr_desc_req_i;
      csr_desc_ack_o    = dq_ack_i;
      csr_desc_data_o   = dq_rdata_i;
    end
  end

  always_comb begin
    rec_data_o       = '{valid: recovery_mode_i & ctl_data_wvalid_i,
                         flush: ctl_data_wflush_i,
                         data:  ctl_data_wdata_i};
    conv_sink_o.data = ctl_data_wdata_i;
    if (recovery_mode_i) begin
      // Only payload bytes reach the data queue
      conv_sink_o.valid = rec_select_i & ctl_data_wvalid_i;
      conv_sink_o.flush = rec_flush_i;
      ctl_data_wready_o = rec_data_ready_i;
      ctl_data_full_o   = 1'b0;
      ctl_data_empty_o  = 1'b0;
    end else begin
      conv_sink_o.valid = ctl_data_wvalid_i;
      conv_sink_o.flush = ctl_data_wflush_i;
      ctl_data_wready_o = conv_sink_ready_i;
      ctl_data_full_o   = data_full_i;
      ctl_data_empty_o  = data_empty_i;
    end
  end

endmodule

`default_nettype wire

/* recovery_receiver.sv */
// Recovery packet parser: cmd, length, payload to data queue, PEC check, command report
`timescale 1ns/10ps
`default_nettype none

module recovery_receiver
  import recovery_pkg::*;
(
  input  logic         clk_i,
  input  logic         rst_i,
  input  logic         desc_valid_i,
  output logic         desc_ready_o,
  input  desc_t        desc_data_i,
  input  byte_stream_t data_i,
  output logic         data_ready_o,
  output logic         data_queue_select_o,
  output logic         data_queue_flush_o,
  input  logic         data_queue_ready_i,
  input  pec_t         pec_crc_i,
  output logic         pec_enable_o,
  output logic         pec_clear_o,
  output rec_cmd_t     cmd_o
);

  rx_state_e state_q;
  rx_state_e state_d;
  len_t      remain_q;
  len_t      pay_cnt_q;
  byte_t     cmd_q;
  len_t      len_q;
  logic      error_q;
  logic      byte_acc;
  logic      last_byte;
  logic      take_pec;

  // Descriptor count exhausted, so this byte ends the packet
  assign last_byte = (remain_q <= len_t'(1));
  assign take_pec  = (state_q == PEC) | last_byte;
  assign byte_acc  = data_i.valid & data_ready_o;

  assign pec_clear_o  = (state_q == IDLE);
  assign pec_enable_o = byte_acc & ~take_pec;

  assign cmd_o = '{valid: (state_q == REPORT), cmd: cmd_q, len: len_q, error: error_q};

  always_comb begin
    state_d             = state_q;
    desc_ready_o        = 1'b0;
    data_ready_o        = 1'b0;
    data_queue_select_o = 1'b0;
    data_queue_flush_o  = 1'b0;
    unique case (state_q)
      IDLE: begin
        desc_ready_o = 1'b1;
        if (desc_valid_i) begin
          state_d = CMD;
        end
      end
      CMD: begin
        data_ready_o = 1'b1;
        if (byte_acc) begin
          state_d = last_byte ? REPORT : LEN_LO;
        end
      end
      LEN_LO: begin
        data_ready_o = 1'b1;
        if (byte_acc) begin
          state_d = last_byte ? REPORT : LEN_HI;
        end
      end
      LEN_HI: begin
        data_ready_o = 1'b1;
        if (byte_acc) begin
          if (last_byte) begin
            state_d = REPORT;
          end else if ({data_i.data, len_q[7:0]} == '0) begin
            state_d = PEC;
          end else begin
            state_d = PAYLOAD;
          end
        end
      end
      PAYLOAD: begin
        data_queue_select_o = ~last_byte;
        data_ready_o        = last_byte | data_queue_ready_i;
        // Flush on the last byte that actually lands in the queue
        data_queue_flush_o  = ~last_byte &
                              ((pay_cnt_q == len_t'(1)) | (remain_q == len_t'(2)));
        if (byte_acc) begin
          if (last_byte) begin
            state_d = REPORT;
          end else if (pay_cnt_q == len_t'(1)) begin
            state_d = PEC;
          end
        end
      end
      PEC: begin
        data_ready_o = 1'b1;
        if (byte_acc) begin
          state_d = REPORT;
        end
      end
      REPORT: begin
        state_d = IDLE;
      end
      default: begin
        state_d = IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q   <= IDLE;
      remain_q  <= '0;
      pay_cnt_q <= '0;
    end else begin
      state_q <= state_d;
      if (desc_valid_i & desc_ready_o) begin
        remain_q <= len_t'(desc_data_i[15:0]);
      end else if (byte_acc) begin
        remain_q <= remain_q - 1'b1;
      end
      if (byte_acc && state_q == LEN_HI) begin
        pay_cnt_q <= {data_i.data, len_q[7:0]};
      end else if (byte_acc && state_q == PAYLOAD) begin
        pay_cnt_q <= pay_cnt_q - 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (desc_valid_i & desc_ready_o) begin
      cmd_q <= '0;
      len_q <= '0;
    end else if (byte_acc & ~take_pec) begin
      case (state_q)
        CMD:     cmd_q <= data_i.data;
        LEN_LO:  len_q[7:0] <= data_i.data;
        LEN_HI:  len_q[15:8] <= data_i.data;
        default: ;
      endcase
    end
    // Error on bad PEC, count mismatch or a packet cut short
    if (byte_acc & take_pec) begin
      error_q <= (data_i.data != pec_crc_i) | (remain_q != len_t'(1)) | (state_q != PEC);
    end
  end

endmodule

`default_nettype wire

/* recovery_pec.sv */
// CRC-8 (poly 0x07, init 0) accumulator over recovery packet bytes, cleared between packets
`timescale 1ns/10ps
`default_nettype none

module recovery_pec
  import recovery_pkg::*;
(
  input  logic  clk_i,
  input  logic  rst_i,
  input  logic  clear_i,
  input  logic  valid_i,
  input  byte_t dat_i,
  output pec_t  crc_o
);

  function automatic pec_t crc8_step(pec_t crc, byte_t dat);
    pec_t c;
    c = crc ^ dat;
    for (int i = 0; i < 8; i++) begin
      c = c[7] ? ({c[6:0], 1'b0} ^ 8'h07) : {c[6:0], 1'b0};
    end
    return c;
  endfunction

  always_ff @(posedge clk_i) begin
    if (rst_i || clear_i) begin
      crc_o <= '0;
    end else if (valid_i) begin
      crc_o <= crc8_step(crc_o, dat_i);
    end
  end

endmodule

`default_nettype wire

/* width_converter_8to32.sv */
// Byte to word packer feeding the RX data queue, little-endian, flush closes a partial word
`timescale 1ns/10ps
`default_nettype none

module width_converter_8to32
  import recovery_pkg::*;
(
  input  logic         clk_i,
  input  logic         rst_i,
  input  byte_stream_t sink_i,
  output logic         sink_ready_o,
  output logic         source_valid_o,
  input  logic         source_ready_i,
  output word_t        source_data_o
);

  localparam int unsigned CntW = $clog2(WordBytes);

  word_t           acc_q;
  word_t           acc_next;
  logic [CntW-1:0] cnt_q;
  logic            out_valid_q;
  logic            accept;
  logic            last;

  // Stall the byte side while a finished word waits on the queue
  assign sink_ready_o   = ~out_valid_q | source_ready_i;
  assign accept         = sink_i.valid & sink_ready_o;
  assign last           = accept & (sink_i.flush | (cnt_q == CntW'(WordBytes - 1)));
  assign source_valid_o = out_valid_q;

  always_comb begin
    acc_next = acc_q;
    acc_next[cnt_q*8 +: 8] = sink_i.data;
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      acc_q       <= '0;
      cnt_q       <= '0;
      out_valid_q <= 1'b0;
    end else begin
      if (out_valid_q & source_ready_i) begin
        out_valid_q <= 1'b0;
      end
      if (last) begin
        // Cleared accumulator zero-fills the high bytes of a flushed word
        acc_q       <= '0;
        cnt_q       <= '0;
        out_valid_q <= 1'b1;
      end else if (accept) begin
        acc_q <= acc_next;
        cnt_q <= cnt_q + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (last) begin
      source_data_o <= acc_next;
    end
  end

endmodule

`default_nettype wire

/* rx_fifo.sv */
// RX queue FIFO, written by the controller side and popped by CSR req/ack reads
`timescale 1ns/10ps
`default_nettype none

module rx_fifo
  import recovery_pkg::*;
#(
  parameter int unsigned Depth = 16
) (
  input  logic  clk_i,
  input  logic  rst_i,
  input  logic  wvalid_i,
  output logic  wready_o,
  input  word_t wdata_i,
  input  logic  req_i,
  output logic  ack_o,
  output word_t rdata_o,
  output logic  full_o,
  output logic  empty_o
);

  localparam int unsigned PtrW = (Depth > 1) ? $clog2(Depth) : 1;
  localparam int unsigned CntW = $clog2(Depth + 1);

  word_t           mem_q [Depth];
  logic [PtrW-1:0] wr_ptr_q;
  logic [PtrW-1:0] rd_ptr_q;
  logic [CntW-1:0] count_q;
  logic            push;
  logic            pop;

  function automatic logic [PtrW-1:0] ptr_inc(logic [PtrW-1:0] ptr);
    return (ptr == PtrW'(Depth - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign full_o   = (count_q == CntW'(Depth));
  assign empty_o  = (count_q == '0);
  assign wready_o = ~full_o;
  assign push     = wvalid_i & wready_o;
  // An empty read still gets acked, it just pops nothing
  assign pop      = req_i & ~empty_o;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
      ack_o    <= 1'b0;
    end else begin
      ack_o <= req_i;
      if (push) begin
        wr_ptr_q <= ptr_inc(wr_ptr_q);
      end
      if (pop) begin
        rd_ptr_q <= ptr_inc(rd_ptr_q);
      end
      if (push & ~pop) begin
        count_q <= count_q + 1'b1;
      end else if (pop & ~push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= wdata_i;
    end
    rdata_o <= pop ? mem_q[rd_ptr_q] : '0;
  end

endmodule

`default_nettype wire

/* recovery_pkg.sv */
// Shared widths, typedefs, stream/command structs and receiver states for the recovery RX path
`default_nettype none

package recovery_pkg;

  // Bytes packed into one queue word
  localparam int unsigned WordBytes = 4;

  typedef logic [7:0] byte_t;
  typedef logic [31:0] word_t;
  typedef logic [31:0] desc_t;
  typedef logic [15:0] len_t;
  typedef logic [7:0] pec_t;

  typedef struct packed {
    logic  valid;
    logic  flush;
    byte_t data;
  } byte_stream_t;

  typedef struct packed {
    logic  valid;
    byte_t cmd;
    len_t  len;
    logic  error;
  } rec_cmd_t;

  typedef enum logic [2:0] {
    IDLE,
    CMD,
    LEN_LO,
    LEN_HI,
    PAYLOAD,
    PEC,
    REPORT
  } rx_state_e;

endpackage

`default_nettype wire
